/* iram_sys.f */
verilog/iram_pkg.sv
verilog/iram_port_if.sv
verilog/iram.sv
verilog/reg_bank_cache.sv
verilog/indirect_addr_unit.sv
verilog/iram_sys_top.sv
dv/iram_sys_tb.sv

/* Makefile */
# Verilator build and run of the internal RAM testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module iram_sys_tb -f iram_sys.f -o sim_iram_sys
	./obj_dir/sim_iram_sys | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/iram_sys_tb.sv */
`timescale 1ns/1ps

module iram_sys_tb import iram_pkg::*; ();

  localparam int clk_period   = 40;
  localparam int reset_cycles = 10;
  localparam int ptr_wait_max = 20;  // Refetch of both pointers after a bank change
  localparam int random_ops   = 200;

  // Rough cycle budget of each test where an access costs 2 cycles plus stalls
  localparam int direct_len  = 40;
  localparam int fill_len    = 30;
  localparam int snoop_len   = 10;
  localparam int switch_len  = 20;
  localparam int memory_len  = 2 * iram_depth;
  localparam int indir_len   = 30;
  localparam int random_len  = 8 * random_ops;
  localparam int timeout_cycles = 2 * (reset_cycles + direct_len + fill_len + snoop_len +
                                       switch_len + memory_len + indir_len + random_len);

  logic              clk;
  logic              rst;
  logic              req;
  logic              we;
  logic              ind;
  logic              ri_sel;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  logic [bank_w-1:0] bank;
  logic [data_w-1:0] rdata;
  logic              rdata_valid;
  logic              busy;
  logic [data_w-1:0] r0;
  logic [data_w-1:0] r1;
  logic              r0_valid;
  logic              r1_valid;

  logic [data_w-1:0]     model [iram_depth];
  logic [iram_depth-1:0] written;  // Bytes with a known value
  int                    cycle_count = 0;

  iram_sys_top u_iram_sys_top (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .we          (we),
    .ind         (ind),
    .ri_sel      (ri_sel),
    .addr        (addr),
    .wdata       (wdata),
    .bank        (bank),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .busy        (busy),
    .r0          (r0),
    .r1          (r1),
    .r0_valid    (r0_valid),
    .r1_valid    (r1_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timed out after %0d cycles with a test still running", cycle_count);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  task automatic end_with_failure();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input string what,
                             input logic [data_w-1:0] expected,
                             input logic [data_w-1:0] actual);
    assert (actual === expected) else begin
      $display("Error: %s %s expected %02h actual %02h", test_name, what, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input string test_name, input string what,
                            input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("Error: %s %s expected %0b actual %0b", test_name, what, expected, actual);
      end_with_failure();
    end
  endtask

  // Address of R0 or R1 inside bank b, which holds bytes 8b to 8b+7
  function automatic logic [addr_w-1:0] reg_addr(input logic [bank_w-1:0] b, input logic sel);
    return addr_w'(8 * int'(b) + int'(sel));
  endfunction

  task automatic drive_idle();
    req    = 1'b0;
    we     = 1'b0;
    ind    = 1'b0;
    ri_sel = 1'b0;
    addr   = '0;
    wdata  = '0;
  endtask

  // One CPU access that is held while busy and checked against the model
  task automatic access(input string test_name, input logic wr, input logic indir,
                        input logic sel, input logic [addr_w-1:0] a,
                        input logic [data_w-1:0] wd, output int stalls);
    logic [addr_w-1:0] ea;
    logic [data_w-1:0] exp_rd;
    logic              ptr_ok;
    stalls = 0;
    exp_rd = '0;
    @(negedge clk);
    check_flag(test_name, "rdata_valid while idle", 1'b0, rdata_valid);
    req    = 1'b1;
    we     = wr;
    ind    = indir;
    ri_sel = sel;
    addr   = a;
    wdata  = wd;
    #(clk_period / 4);
    ptr_ok = sel ? r1_valid : r0_valid;
    while (indir && !ptr_ok) begin
      check_flag(test_name, "busy with pointer invalid", 1'b1, busy);
      stalls++;
      @(negedge clk);  // Request stays on the inputs
      #(clk_period / 4);
      ptr_ok = sel ? r1_valid : r0_valid;
    end
    check_flag(test_name, "busy", 1'b0, busy);
    if (indir) begin
      ea = model[reg_addr(bank, sel)];
      if (sel) check_value(test_name, "r1 pointer", ea, r1);
      else check_value(test_name, "r0 pointer", ea, r0);
    end else begin
      ea = a;
    end
    if (wr) begin
      model[ea]   = wd;
      written[ea] = 1'b1;
    end else begin
      assert (written[ea]) else begin
        $display("%s reads address %02h before it was ever written", test_name, ea);
        end_with_failure();
      end
      exp_rd = model[ea];
    end
    @(posedge clk);  // Accepted here
    @(negedge clk);
    check_flag(test_name, "rdata_valid", !wr, rdata_valid);
    if (!wr) check_value(test_name, "rdata", exp_rd, rdata);
    drive_idle();
  endtask

  task automatic set_bank(input logic [bank_w-1:0] b);
    @(negedge clk);
    bank = b;
  endtask

  task automatic wait_pointers(input string test_name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(r0_valid && r1_valid)) begin
      waited++;
      assert (waited < ptr_wait_max) else begin
        $display("%s: R0 and R1 did not become valid within %0d cycles", test_name, waited);
        end_with_failure();
      end
      @(negedge clk);
    end
    check_value(test_name, "r0", model[reg_addr(bank, 1'b0)], r0);
    check_value(test_name, "r1", model[reg_addr(bank, 1'b1)], r1);
  endtask

  task automatic reset_state_check();
    check_flag("reset", "rdata_valid", 1'b0, rdata_valid);
    check_flag("reset", "busy", 1'b0, busy);
    check_flag("reset", "r0_valid", 1'b0, r0_valid);
    check_flag("reset", "r1_valid", 1'b0, r1_valid);
    check_value("reset", "r0", '0, r0);
    check_value("reset", "r1", '0, r1);
  endtask

  task automatic direct_rw_test();
    logic [addr_w-1:0] addrs [$];
    int                stalls;
    for (int k = 0; k < 8; k++) begin
      addrs.push_back(addr_w'($urandom()));
    end
    addrs.push_back(8'h7f);
    addrs.push_back(8'hff);
    foreach (addrs[k]) begin
      access("direct_rw", 1'b1, 1'b0, 1'b0, addrs[k], data_w'($urandom()), stalls);
    end
    for (int k = addrs.size() - 1; k >= 0; k--) begin
      access("direct_rw", 1'b0, 1'b0, 1'b0, addrs[k], '0, stalls);
    end
  endtask

  task automatic pointer_fill_test();
    int stalls;
    for (int i = 0; i < 8; i++) begin
      access("pointer_fill", 1'b1, 1'b0, 1'b0, addr_w'(i), data_w'($urandom()), stalls);
    end
    wait_pointers("pointer_fill");
  endtask

  task automatic write_snoop_test();
    logic [data_w-1:0] v;
    int                stalls;
    v = data_w'($urandom());
    access("write_snoop", 1'b1, 1'b0, 1'b0, reg_addr(bank, 1'b1), v, stalls);
    check_flag("write_snoop", "r1_valid", 1'b1, r1_valid);
    check_value("write_snoop", "r1", v, r1);
    // R1 of the next bank is not cached
    access("write_snoop", 1'b1, 1'b0, 1'b0, reg_addr(bank + 2'd1, 1'b1), ~v, stalls);
    check_value("write_snoop", "r1 after other bank write", v, r1);
  endtask

  task automatic bank_switch_test();
    int stalls;
    access("bank_switch", 1'b1, 1'b0, 1'b0, 8'd16, data_w'($urandom()), stalls);
    access("bank_switch", 1'b1, 1'b0, 1'b0, 8'd17, data_w'($urandom()), stalls);
    set_bank(2'd2);
    @(negedge clk);
    check_flag("bank_switch", "r0_valid after switch", 1'b0, r0_valid);
    check_flag("bank_switch", "r1_valid after switch", 1'b0, r1_valid);
    wait_pointers("bank_switch");
  endtask

  task automatic fill_memory();
    int stalls;
    for (int i = 0; i < iram_depth; i++) begin
      access("fill_memory", 1'b1, 1'b0, 1'b0, addr_w'(i), data_w'($urandom()), stalls);
    end
  endtask

  task automatic indirect_test();
    logic [addr_w-1:0] target;
    int                stalls;
    set_bank(2'd3);
    access("indirect", 1'b0, 1'b1, 1'b0, '0, '0, stalls);  // Read at R0 right after the switch
    assert (stalls > 0) else begin
      $display("indirect: busy never rose while R0 was being refetched");
      end_with_failure();
    end
    target = model[reg_addr(bank, 1'b1)];
    access("indirect", 1'b1, 1'b1, 1'b1, '0, data_w'($urandom()), stalls);
    access("indirect", 1'b0, 1'b0, 1'b0, target, '0, stalls);
  endtask

  task automatic random_mix_test();
    int stalls;
    for (int n = 0; n < random_ops; n++) begin
      if (($urandom() % 8) == 0) begin
        set_bank(bank_w'($urandom()));
      end else begin
        access("random_mix", 1'($urandom()), 1'($urandom()), 1'($urandom()),
               addr_w'($urandom()), data_w'($urandom()), stalls);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hb69e7786));
    rst     = 1'b1;
    bank    = '0;
    written = '0;
    drive_idle();
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    reset_state_check();
    direct_rw_test();
    pointer_fill_test();
    write_snoop_test();
    bank_switch_test();
    fill_memory();
    indirect_test();
    random_mix_test();
    $display("Testbench passed");
    $finish;
  end

endmodule

/* verilog/iram_sys_top.sv */
`timescale 1ns/1ps

module iram_sys_top import iram_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic              we,
  input  logic              ind,
  input  logic              ri_sel,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  input  logic [bank_w-1:0] bank,
  output logic [data_w-1:0] rdata,
  output logic              rdata_valid,
  output logic              busy,
  output logic [data_w-1:0] r0,
  output logic [data_w-1:0] r1,
  output logic              r0_valid,
  output logic              r1_valid
);

  // Access unit to cache, and cache to RAM
  iram_port_if cpu_port ();
  iram_port_if mem_port ();

  indirect_addr_unit u_indirect_addr_unit (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .we          (we),
    .ind         (ind),
    .ri_sel      (ri_sel),
    .addr        (addr),
    .wdata       (wdata),
    .r0          (r0),
    .r1          (r1),
    .r0_valid    (r0_valid),
    .r1_valid    (r1_valid),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .busy        (busy),
    .cpu_port    (cpu_port.requester)
  );

  reg_bank_cache u_reg_bank_cache (
    .clk      (clk),
    .rst      (rst),
    .bank     (bank),
    .cpu_port (cpu_port.responder),
    .mem_port (mem_port.requester),
    .r0       (r0),
    .r1       (r1),
    .r0_valid (r0_valid),
    .r1_valid (r1_valid)
  );

  iram u_iram (
    .clk  (clk),
    .port (mem_port.responder)
  );

endmodule

/* verilog/indirect_addr_unit.sv */
`timescale 1ns/1ps

module indirect_addr_unit import iram_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic              we,
  input  logic              ind,     // Indirect access through R0 or R1
  input  logic              ri_sel,  // Low picks R0, high picks R1
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  input  logic [data_w-1:0] r0,
  input  logic [data_w-1:0] r1,
  input  logic              r0_valid,
  input  logic              r1_valid,
  output logic [data_w-1:0] rdata,
  output logic              rdata_valid,
  output logic              busy,
  iram_port_if.requester    cpu_port
);

  logic [data_w-1:0] ri_ptr;
  logic              ri_ok;
  logic [addr_w-1:0] eff_addr;
  logic              accept;
  logic              rd_accept;

  assign ri_ptr = ri_sel ? r1 : r0;
  assign ri_ok  = ri_sel ? r1_valid : r0_valid;

  // Pointer bytes are used as RAM addresses as they are
  assign eff_addr = ind ? addr_w'(ri_ptr) : addr;

  // Stall only while the selected pointer is still being fetched
  assign busy   = req && ind && !ri_ok;
  assign accept = req && !busy;

  assign rd_accept = accept && !we;

  assign cpu_port.rd_en   = rd_accept;
  assign cpu_port.rd_addr = eff_addr;
  assign cpu_port.wr_en   = accept && we;
  assign cpu_port.wr_addr = eff_addr;
  assign cpu_port.wr_data = wdata;

  assign rdata = cpu_port.rd_data;

  // RAM data lands on the same edge as this flag
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata_valid <= 1'b0;
    end else begin
      rdata_valid <= rd_accept;
    end
  end

endmodule

/* verilog/reg_bank_cache.sv */
`timescale 1ns/1ps

module reg_bank_cache import iram_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [bank_w-1:0] bank,
  iram_port_if.responder    cpu_port,
  iram_port_if.requester    mem_port,
  output logic [data_w-1:0] r0,
  output logic [data_w-1:0] r1,
  output logic              r0_valid,
  output logic              r1_valid
);

  typedef enum logic [1:0] {
    st_init,
    st_fetch_r0,
    st_fetch_r1,
    st_valid
  } state_t;

  state_t state;
  state_t state_nx;

  logic [bank_w-1:0] bank_q;
  logic              bank_change;

  logic [addr_w-1:0] bank_base;
  logic [addr_w-1:0] ri_addr [2];
  logic [data_w-1:0] ri_q [2];
  logic [1:0]        ri_valid;
  logic [1:0]        snoop_hit;
  logic [1:0]        capture;

  logic in_fetch;
  logic fetch_sel;  // Low for R0, high for R1
  logic fetch_rd;
  logic pending;    // Fetch data arrives on mem_port this cycle

  assign bank_base  = addr_w'(bank) << bank_shift;
  assign ri_addr[0] = bank_base + addr_w'(ri_offset_r0);
  assign ri_addr[1] = bank_base + addr_w'(ri_offset_r1);

  assign bank_change = (bank != bank_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      bank_q <= '0;
    end else begin
      bank_q <= bank;
    end
  end

  assign in_fetch  = (state == st_fetch_r0) || (state == st_fetch_r1);
  assign fetch_sel = (state == st_fetch_r1);

  // The CPU owns the read port whenever it reads
  assign fetch_rd = in_fetch && !pending && !ri_valid[fetch_sel] &&
                    !cpu_port.rd_en && !bank_change;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else begin
      pending <= fetch_rd;
    end
  end

  always_comb begin
    state_nx = state;
    if (bank_change) begin
      state_nx = st_fetch_r0;  // Old pointers are stale so fetching starts over
    end else begin
      case (state)
        st_init: state_nx = st_fetch_r0;
        st_fetch_r0: begin
          if (pending || ri_valid[0]) state_nx = st_fetch_r1;
        end
        st_fetch_r1: begin
          if (pending || ri_valid[1]) state_nx = st_valid;
        end
        st_valid: state_nx = st_valid;  // Both pointers hold until the next bank change
        default: state_nx = st_init;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_init;
    end else begin
      state <= state_nx;
    end
  end

  // Writes to the pointer addresses of the selected bank
  assign snoop_hit[0] = cpu_port.wr_en && (cpu_port.wr_addr == ri_addr[0]);
  assign snoop_hit[1] = cpu_port.wr_en && (cpu_port.wr_addr == ri_addr[1]);

  // Fetched byte is taken on the edge that leaves the fetch state
  assign capture[0] = pending && (state == st_fetch_r0) && !ri_valid[0];
  assign capture[1] = pending && (state == st_fetch_r1) && !ri_valid[1];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (rst) begin
        ri_q[i]     <= '0;
        ri_valid[i] <= 1'b0;
      end else if (snoop_hit[i]) begin
        // The write is newer than anything a fetch could return
        ri_q[i]     <= cpu_port.wr_data;
        ri_valid[i] <= 1'b1;
      end else if (bank_change) begin
        ri_valid[i] <= 1'b0;
      end else if (capture[i]) begin
        ri_q[i]     <= mem_port.rd_data;
        ri_valid[i] <= 1'b1;
      end
    end
  end

  assign mem_port.rd_en   = cpu_port.rd_en || fetch_rd;
  assign mem_port.rd_addr = cpu_port.rd_en ? cpu_port.rd_addr : ri_addr[fetch_sel];
  assign cpu_port.rd_data = mem_port.rd_data;

  // Writes go straight through to the RAM
  assign mem_port.wr_en   = cpu_port.wr_en;
  assign mem_port.wr_addr = cpu_port.wr_addr;
  assign mem_port.wr_data = cpu_port.wr_data;

  assign r0       = ri_q[0];
  assign r1       = ri_q[1];
  assign r0_valid = ri_valid[0];
  assign r1_valid = ri_valid[1];

endmodule

/* verilog/iram.sv */
`timescale 1ns/1ps

module iram import iram_pkg::*; (
  input logic clk,
  iram_port_if.responder port
);

  logic [data_w-1:0] mem [iram_depth];

  // Write port
  always_ff @(posedge clk) begin
    if (port.wr_en) begin
      mem[port.wr_addr] <= port.wr_data;
    end
  end

  // A read of the byte being written in the same cycle returns the old contents
  always_ff @(posedge clk) begin
    if (port.rd_en) begin
      port.rd_data <= mem[port.rd_addr];
    end
  end

endmodule

/* verilog/iram_port_if.sv */
`timescale 1ns/1ps

interface iram_port_if import iram_pkg::*; ();

  logic              rd_en;    // One cycle read strobe
  logic [addr_w-1:0] rd_addr;
  logic [data_w-1:0] rd_data;  // Valid the cycle after the strobe
  logic              wr_en;
  logic [addr_w-1:0] wr_addr;
  logic [data_w-1:0] wr_data;

  modport requester (
    output rd_en,
    output rd_addr,
    input  rd_data,
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport responder (
    input  rd_en,
    input  rd_addr,
    output rd_data,
    input  wr_en,
    input  wr_addr,
    input  wr_data
  );

endinterface

/* verilog/iram_pkg.sv */
package iram_pkg;

  // Byte and address widths of the internal data memory
  localparam int data_w = 8;
  localparam int addr_w = 8;

  // PSW style bank select over four banks of eight registers
  localparam int bank_w = 2;

  localparam int iram_depth = 256;  // Lower and upper 128 bytes together

  // Position of the two pointer registers inside a bank
  localparam int ri_offset_r0 = 0;
  localparam int ri_offset_r1 = 1;

  // Bank n starts at byte 8n
  localparam int bank_shift = 3;

endpackage
